// ==== rtl/red_cfg.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reduction controller configuration
// Route count, data width, pipeline and
// metadata FIFO sizing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef RED_CFG_SVH
`define RED_CFG_SVH

// Number of NoC input routes feeding the controller
`define RED_NUM_ROUTES 4

// Width of the flit data field
`define RED_DATA_W 16

// Stages in the reduction pipeline
`define RED_ALU_DEPTH 3

// Metadata FIFO depth, two spare entries over the pipeline
`define RED_FIFO_DEPTH (`RED_ALU_DEPTH + 2)

`endif

// ==== rtl/red_op_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reduction operation encoding
// Carried in every flit header
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package red_op_pkg;

    // Width of the operation field
    localparam int unsigned RED_OP_W = 2;

    // Operation requested by the lower-indexed flit of a pair
    // op_select marks a protocol header that bypasses the reduction
    typedef enum logic [RED_OP_W-1:0] {
        // Sum, wraps at the data width
        op_add    = 2'd0,
        // Unsigned minimum
        op_min    = 2'd1,
        // Unsigned maximum
        op_max    = 2'd2,
        // Forward once, no reduction
        op_select = 2'd3
    } red_op_e;

endpackage

// ==== rtl/red_flit_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Flit, header and route mask types
// Shared by all controller blocks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "red_cfg.svh"

package red_flit_pkg;

    // One bit per input route
    typedef logic [`RED_NUM_ROUTES-1:0] route_mask_t;

    // Index of a single route
    typedef logic [$clog2(`RED_NUM_ROUTES)-1:0] route_idx_t;

    // Payload word
    typedef logic [`RED_DATA_W-1:0] red_data_t;

    // Flit header, 18 bits
    typedef struct packed {
        // Requested operation
        red_op_pkg::red_op_e op;
        // Routes that take part in this item
        route_mask_t         exp_mask;
        // Output direction of the result
        route_mask_t         out_dir;
        // Sequence id, opaque to the RTL
        logic [7:0]          seq_id;
    } red_hdr_t;

    // Full flit, header on top of data, 34 bits
    typedef struct packed {
        red_hdr_t  hdr;
        red_data_t data;
    } red_flit_t;

endpackage

// ==== rtl/red_pair_sched.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Pair scheduler
// Picks the two lowest valid routes and
// issues a reduction or a bypass flit
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "red_cfg.svh"

module red_pair_sched (
    input  logic                                         clk_i,
    input  logic                                         rst_n_i,
    input  red_flit_pkg::red_flit_t [`RED_NUM_ROUTES-1:0] in_flit_i,
    input  logic [`RED_NUM_ROUTES-1:0]                   in_valid_i,
    output logic [`RED_NUM_ROUTES-1:0]                   in_ready_o,
    input  logic                                         fifo_empty_i,
    output red_flit_pkg::red_data_t                      op_a_o,
    output red_flit_pkg::red_data_t                      op_b_o,
    output red_op_pkg::red_op_e                          op_o,
    output red_flit_pkg::red_hdr_t                       issue_hdr_o,
    output logic                                         issue_valid_o,
    input  logic                                         issue_ready_i,
    output red_flit_pkg::red_flit_t                      byp_flit_o,
    output logic                                         byp_valid_o,
    input  logic                                         byp_ready_i
);

    import red_flit_pkg::*;
    import red_op_pkg::*;

    // Search results over the current inputs
    logic       found_a, found_b;
    route_idx_t sel_a, sel_b;

    // Lock holds the chosen pair until it is accepted
    logic       lock_q, lock_d;
    route_idx_t idx_a_q, idx_b_q;

    // Pair actually in use this cycle
    route_idx_t  cur_a, cur_b;
    red_flit_t   lead_flit;
    logic        is_select;
    logic        active;
    logic        mask_ready;
    logic        issue_hs, byp_hs;
    route_mask_t pair_mask;

    // Lowest two valid routes, lower index first
    always_comb begin
        found_a = 1'b0;
        found_b = 1'b0;
        sel_a   = '0;
        sel_b   = '0;
        for (int i = 0; i < `RED_NUM_ROUTES; i++) begin
            if (in_valid_i[i]) begin
                if (!found_a) begin
                    found_a = 1'b1;
                    sel_a   = route_idx_t'(i);
                end else if (!found_b) begin
                    found_b = 1'b1;
                    sel_b   = route_idx_t'(i);
                end
            end
        end
    end

    // Locked pair wins over a fresh search
    assign cur_a     = lock_q ? idx_a_q : sel_a;
    assign cur_b     = lock_q ? idx_b_q : sel_b;
    assign lead_flit = in_flit_i[cur_a];
    assign is_select = (lead_flit.hdr.op == op_select);

    // A select flit needs only its own route to start
    assign active = lock_q | (found_a & (found_b | is_select));

    // All routes named by the select header must be present
    assign mask_ready = ((in_valid_i & lead_flit.hdr.exp_mask) == lead_flit.hdr.exp_mask);

    // Reduction request towards pipeline and FIFOs
    assign op_a_o        = lead_flit.data;
    assign op_b_o        = in_flit_i[cur_b].data;
    assign op_o          = lead_flit.hdr.op;
    assign issue_hdr_o   = lead_flit.hdr;
    assign issue_valid_o = active & ~is_select;

    // Bypass waits for an empty pipeline to keep ordering
    assign byp_flit_o  = lead_flit;
    assign byp_valid_o = active & is_select & fifo_empty_i & mask_ready;

    assign issue_hs  = issue_valid_o & issue_ready_i;
    assign byp_hs    = byp_valid_o & byp_ready_i;
    assign pair_mask = (route_mask_t'(1) << cur_a) | (route_mask_t'(1) << cur_b);

    // Inputs are only released on a handshake
    always_comb begin
        in_ready_o = '0;
        if (issue_hs) begin
            in_ready_o = pair_mask;
        end else if (byp_hs) begin
            in_ready_o = lead_flit.hdr.exp_mask;
        end
    end

    // Hold the pair while waiting, drop it once accepted
    assign lock_d = active & ~(issue_hs | byp_hs);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            lock_q  <= 1'b0;
            idx_a_q <= '0;
            idx_b_q <= '0;
        end else begin
            lock_q  <= lock_d;
            idx_a_q <= cur_a;
            idx_b_q <= cur_b;
        end
    end

    // Reduction and bypass are exclusive
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(issue_valid_o && byp_valid_o));

    // A pending issue keeps its pair and stays offered
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (issue_valid_o && !issue_ready_i) |=>
            (issue_valid_o && cur_a == $past(cur_a) && cur_b == $past(cur_b)));

endmodule

// ==== rtl/red_alu_pipe.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reduction pipeline
// Add, min or max in the first stage,
// then a stalling valid-tagged shift
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "red_cfg.svh"

module red_alu_pipe (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  red_flit_pkg::red_data_t op_a_i,
    input  red_flit_pkg::red_data_t op_b_i,
    input  red_op_pkg::red_op_e     op_i,
    input  logic                    in_valid_i,
    output logic                    in_ready_o,
    output red_flit_pkg::red_data_t res_data_o,
    output logic                    res_valid_o,
    input  logic                    res_ready_i
);

    import red_flit_pkg::*;
    import red_op_pkg::*;

    localparam int unsigned DEPTH = `RED_ALU_DEPTH;

    // Stage registers, index 0 takes the fresh result
    red_data_t        stage_data_q [DEPTH];
    logic [DEPTH-1:0] stage_vld_q;

    red_data_t alu_res;
    logic      stall;

    // Whole pipe freezes while the last stage is blocked
    assign stall      = res_valid_o & ~res_ready_i;
    assign in_ready_o = ~stall;

    // Unsigned operations, add wraps naturally
    always_comb begin
        case (op_i)
            op_add:  alu_res = op_a_i + op_b_i;
            op_min:  alu_res = (op_a_i < op_b_i) ? op_a_i : op_b_i;
            op_max:  alu_res = (op_a_i > op_b_i) ? op_a_i : op_b_i;
            default: alu_res = op_a_i;
        endcase
    end

    // Valid tags
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            stage_vld_q <= '0;
        end else if (!stall) begin
            stage_vld_q <= {stage_vld_q[DEPTH-2:0], in_valid_i};
        end
    end

    // Data path shifts with the tags
    always_ff @(posedge clk_i) begin
        if (!stall) begin
            stage_data_q[0] <= alu_res;
            for (int i = 1; i < DEPTH; i++) begin
                stage_data_q[i] <= stage_data_q[i-1];
            end
        end
    end

    assign res_data_o  = stage_data_q[DEPTH-1];
    assign res_valid_o = stage_vld_q[DEPTH-1];

    // Result holds until taken
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (res_valid_o && !res_ready_i) |=> (res_valid_o && $stable(res_data_o)));

endmodule

// ==== rtl/red_hdr_fifo.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Metadata FIFO
// Circular buffer, head visible without
// a read cycle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module red_hdr_fifo #(
    parameter type         payload_t = logic,
    parameter int unsigned DEPTH     = 4
) (
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  payload_t data_i,
    input  logic     push_i,
    output payload_t data_o,
    input  logic     pop_i,
    output logic     empty_o
);

    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    // Storage
    payload_t mem_q [DEPTH];

    logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             full;
    logic             do_push, do_pop;

    assign full    = (count_q == CNT_W'(DEPTH));
    assign empty_o = (count_q == '0);

    // Overflow and underflow are dropped
    assign do_push = push_i & ~full;
    assign do_pop  = pop_i & ~empty_o;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            // Pointers wrap at DEPTH, which need not be a power of two
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            if (do_push && !do_pop) begin
                count_q <= count_q + 1'b1;
            end else if (do_pop && !do_push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

    // Head of queue
    assign data_o = mem_q[rd_ptr_q];

    // Upstream must respect the capacity
    assert property (@(posedge clk_i) disable iff (!rst_n_i) push_i |-> !full);

    // Every result handshake has parked metadata
    assert property (@(posedge clk_i) disable iff (!rst_n_i) pop_i |-> !empty_o);

endmodule

// ==== rtl/red_out_merge.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Output merger
// Rebuilds reduced flits and shares the
// output with the bypass, round robin
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module red_out_merge (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  red_flit_pkg::red_data_t  res_data_i,
    input  logic                     res_valid_i,
    output logic                     res_ready_o,
    input  red_flit_pkg::red_hdr_t   hdr_i,
    input  red_flit_pkg::route_mask_t dir_i,
    input  red_flit_pkg::red_flit_t  byp_flit_i,
    input  logic                     byp_valid_i,
    output logic                     byp_ready_o,
    output red_flit_pkg::red_flit_t  out_flit_o,
    output logic                     out_valid_o,
    input  logic                     out_ready_i
);

    import red_flit_pkg::*;

    // Flit rebuilt from the parked metadata
    red_flit_t res_flit;

    // Priority pointer, high favours the bypass
    logic rr_q;
    logic grant_res, grant_byp;
    logic out_hs;

    // Header from FIFO A, direction from FIFO B
    always_comb begin
        res_flit             = '0;
        res_flit.hdr         = hdr_i;
        res_flit.hdr.out_dir = dir_i;
        res_flit.data        = res_data_i;
    end

    // Single requester always wins, pointer breaks ties
    assign grant_res = res_valid_i & (~byp_valid_i | ~rr_q);
    assign grant_byp = byp_valid_i & (~res_valid_i | rr_q);

    assign out_valid_o = res_valid_i | byp_valid_i;
    assign out_flit_o  = grant_byp ? byp_flit_i : res_flit;
    assign res_ready_o = out_ready_i & grant_res;
    assign byp_ready_o = out_ready_i & grant_byp;

    assign out_hs = out_valid_o & out_ready_i;

    // Advance only on a transfer, other side gets the next tie
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rr_q <= 1'b0;
        end else if (out_hs) begin
            rr_q <= grant_res;
        end
    end

    // Scheduler keeps bypass and results apart, so a held output never switches source
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (out_valid_o && !out_ready_i) |=> (out_valid_o && $stable(out_flit_o)));

endmodule

// ==== rtl/red_ctrl_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reduction controller top level
// Scheduler, pipeline, metadata FIFOs
// and output merger
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "red_cfg.svh"

module red_ctrl_top (
    input  logic                                         clk_i,
    input  logic                                         rst_n_i,
    input  red_flit_pkg::red_flit_t [`RED_NUM_ROUTES-1:0] in_flit_i,
    input  logic [`RED_NUM_ROUTES-1:0]                   in_valid_i,
    output logic [`RED_NUM_ROUTES-1:0]                   in_ready_o,
    output red_flit_pkg::red_flit_t                      out_flit_o,
    output logic                                         out_valid_o,
    input  logic                                         out_ready_i
);

    import red_flit_pkg::*;
    import red_op_pkg::*;

    // Scheduler to pipeline
    red_data_t op_a, op_b;
    red_op_e   op;
    logic      issue_valid, issue_ready;

    // Metadata captured on issue
    red_hdr_t    issue_hdr;
    red_hdr_t    hdr_head;
    route_mask_t dir_head;
    logic        fifo_empty;

    // Bypass path
    red_flit_t byp_flit;
    logic      byp_valid, byp_ready;

    // Pipeline results
    red_data_t res_data;
    logic      res_valid, res_ready;

    red_pair_sched u_sched (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .in_flit_i     (in_flit_i),
        .in_valid_i    (in_valid_i),
        .in_ready_o    (in_ready_o),
        .fifo_empty_i  (fifo_empty),
        .op_a_o        (op_a),
        .op_b_o        (op_b),
        .op_o          (op),
        .issue_hdr_o   (issue_hdr),
        .issue_valid_o (issue_valid),
        .issue_ready_i (issue_ready),
        .byp_flit_o    (byp_flit),
        .byp_valid_o   (byp_valid),
        .byp_ready_i   (byp_ready)
    );

    red_alu_pipe u_alu (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .op_a_i      (op_a),
        .op_b_i      (op_b),
        .op_i        (op),
        .in_valid_i  (issue_valid),
        .in_ready_o  (issue_ready),
        .res_data_o  (res_data),
        .res_valid_o (res_valid),
        .res_ready_i (res_ready)
    );

    // Header parked per reduction, its emptiness gates the bypass
    red_hdr_fifo #(
        .payload_t (red_hdr_t),
        .DEPTH     (`RED_FIFO_DEPTH)
    ) u_hdr_fifo (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .data_i  (issue_hdr),
        .push_i  (issue_valid & issue_ready),
        .data_o  (hdr_head),
        .pop_i   (res_valid & res_ready),
        .empty_o (fifo_empty)
    );

    // Output direction travels beside the header
    red_hdr_fifo #(
        .payload_t (route_mask_t),
        .DEPTH     (`RED_FIFO_DEPTH)
    ) u_dir_fifo (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .data_i  (issue_hdr.out_dir),
        .push_i  (issue_valid & issue_ready),
        .data_o  (dir_head),
        .pop_i   (res_valid & res_ready),
        .empty_o ()
    );

    red_out_merge u_merge (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .res_data_i  (res_data),
        .res_valid_i (res_valid),
        .res_ready_o (res_ready),
        .hdr_i       (hdr_head),
        .dir_i       (dir_head),
        .byp_flit_i  (byp_flit),
        .byp_valid_i (byp_valid),
        .byp_ready_o (byp_ready),
        .out_flit_o  (out_flit_o),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i)
    );

endmodule

// ==== test/tb_red_ctrl.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reduction controller testbench
// LFSR stimulus, expected-flit queue and
// concurrent output checks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "red_cfg.svh"

module tb_red_ctrl;

    import red_flit_pkg::*;
    import red_op_pkg::*;

    localparam logic [15:0] SEED        = 16'd33;
    localparam int          N_ITEMS     = 24;
    localparam int          ACC_LIMIT   = 200;
    localparam int          DRAIN_LIMIT = 2000;

    logic                            clk;
    logic                            rst_n;
    red_flit_t [`RED_NUM_ROUTES-1:0] in_flit;
    logic [`RED_NUM_ROUTES-1:0]      in_valid;
    logic [`RED_NUM_ROUTES-1:0]      in_ready;
    red_flit_t                       out_flit;
    logic                            out_valid;
    logic                            out_ready = 1'b1;

    // Separate LFSR streams for items and for output stalls
    logic [15:0] stim_lfsr  = SEED;
    logic [15:0] stall_lfsr = SEED;
    logic        stall_en   = 1'b0;
    logic        quiet_chk  = 1'b0;
    logic        hung       = 1'b0;

    // Expected flits in issue order, pointer value is also the sequence id
    red_flit_t  exp_mem [256];
    logic [7:0] wr_ptr   = 8'd0;
    logic [7:0] rd_ptr   = 8'd0;
    logic       out_hs_q = 1'b0;

    int err_cnt      = 0;
    int tests_run    = 0;
    int tests_failed = 0;

    red_ctrl_top u_red_ctrl_top (
        .clk_i       (clk),
        .rst_n_i     (rst_n),
        .in_flit_i   (in_flit),
        .in_valid_i  (in_valid),
        .in_ready_o  (in_ready),
        .out_flit_o  (out_flit),
        .out_valid_o (out_valid),
        .out_ready_i (out_ready)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // 16-bit Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // One LFSR step per bit taken
    task automatic rand_bits(input int n, output logic [15:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            stim_lfsr = lfsr_next(stim_lfsr);
            val = {val[14:0], stim_lfsr[0]};
        end
    endtask

    // Add, min or max; code 3 folds onto add
    task automatic pick_op(output red_op_e op);
        logic [15:0] r;
        rand_bits(2, r);
        op = (r[1:0] == 2'd3) ? op_add : red_op_e'(r[1:0]);
    endtask

    // Reference reduction, add wraps at 16 bits
    function automatic red_data_t reduce_ref(input red_op_e op, input red_data_t a,
                                             input red_data_t b);
        case (op)
            op_min:  return (a <= b) ? a : b;
            op_max:  return (a >= b) ? a : b;
            default: return red_data_t'(a + b);
        endcase
    endfunction

    task automatic record_expected(input red_flit_t f);
        exp_mem[wr_ptr] = f;
        wr_ptr = wr_ptr + 8'd1;
    endtask

    // Block this process for good, the watchdog below ends the run
    task automatic give_up();
        hung = 1'b1;
        forever @(posedge clk);
    endtask

    // Hold the item until the DUT raises a ready, then withdraw it
    task automatic wait_accept(input route_mask_t mask);
        int cycles;
        cycles = 0;
        in_valid = mask;
        @(negedge clk);
        while (in_ready == '0) begin
            cycles = cycles + 1;
            if (cycles > ACC_LIMIT) begin
                $display("timeout: inputs %b were never accepted at time %0t", mask, $time);
                give_up();
            end
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        in_valid = '0;
    endtask

    // Two routes, header taken from the lower one
    task automatic send_pair(input red_op_e op);
        logic [15:0] r;
        route_idx_t  lo, hi, tmp;
        route_mask_t mask;
        red_flit_t   lead, other, exp;
        rand_bits(2, r);
        lo = r[1:0];
        rand_bits(2, r);
        hi = r[1:0];
        if (hi == lo) begin
            hi = lo + 2'd1;
        end
        if (hi < lo) begin
            tmp = lo;
            lo  = hi;
            hi  = tmp;
        end
        mask = (route_mask_t'(1) << lo) | (route_mask_t'(1) << hi);
        lead.hdr.op       = op;
        lead.hdr.exp_mask = mask;
        rand_bits(4, r);
        lead.hdr.out_dir  = r[3:0];
        lead.hdr.seq_id   = wr_ptr;
        rand_bits(16, r);
        lead.data         = r;
        // Upper header is junk on purpose, only the lower one may count
        rand_bits(2, r);
        other.hdr.op       = red_op_e'(r[1:0]);
        other.hdr.exp_mask = mask;
        other.hdr.out_dir  = ~lead.hdr.out_dir;
        other.hdr.seq_id   = ~wr_ptr;
        rand_bits(16, r);
        other.data         = r;
        in_flit     = '0;
        in_flit[lo] = lead;
        in_flit[hi] = other;
        exp.hdr  = lead.hdr;
        exp.data = reduce_ref(op, lead.data, other.data);
        record_expected(exp);
        wait_accept(mask);
    endtask

    // Same select flit on every route, only masked routes are valid
    task automatic send_select();
        logic [15:0] r;
        route_mask_t mask;
        red_flit_t   f;
        rand_bits(4, r);
        mask = (r[3:0] == 4'd0) ? route_mask_t'(1) : r[3:0];
        f.hdr.op       = op_select;
        f.hdr.exp_mask = mask;
        rand_bits(4, r);
        f.hdr.out_dir  = r[3:0];
        f.hdr.seq_id   = wr_ptr;
        rand_bits(16, r);
        f.data         = r;
        in_flit = {`RED_NUM_ROUTES{f}};
        record_expected(f);
        wait_accept(mask);
    endtask

    // Wait until every expected flit has come out
    task automatic drain();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (wr_ptr != rd_ptr) begin
            cycles = cycles + 1;
            if (cycles > DRAIN_LIMIT) begin
                $display("timeout: %0d expected flits never came out", wr_ptr - rd_ptr);
                give_up();
            end
            @(negedge clk);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic close_test(input string name, input int errs_before);
        drain();
        tests_run = tests_run + 1;
        if (err_cnt == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed = tests_failed + 1;
            $display("test %s: %0d check(s) failed", name, err_cnt - errs_before);
        end
    endtask

    // Output back-pressure, one LFSR bit per cycle while enabled
    always @(posedge clk) begin
        #1;
        if (stall_en) begin
            stall_lfsr = lfsr_next(stall_lfsr);
            out_ready  = stall_lfsr[0];
        end else begin
            out_ready = 1'b1;
        end
    end

    // Handshake seen at the stable half cycle retires the head at the next edge
    always @(negedge clk) begin
        out_hs_q <= out_valid & out_ready;
    end

    always @(posedge clk) begin
        if (out_hs_q && rd_ptr != wr_ptr) begin
            rd_ptr <= rd_ptr + 8'd1;
        end
    end

    // Quiet handshakes in reset and on the first cycle after it
    assert property (@(negedge clk) (!rst_n || quiet_chk) |-> (!out_valid && in_ready == '0))
        else begin
            err_cnt = err_cnt + 1;
            $display("error %0t: valid or ready high around reset", $time);
        end

    // Each transfer is the oldest expected flit
    assert property (@(negedge clk) disable iff (!rst_n)
        (out_valid && out_ready) |-> (wr_ptr != rd_ptr && out_flit == exp_mem[rd_ptr]))
        else begin
            err_cnt = err_cnt + 1;
            $display("error %0t: output flit %h, expected %h", $time, out_flit,
                     exp_mem[rd_ptr]);
        end

    // Issue order holds, selects included
    assert property (@(negedge clk) disable iff (!rst_n)
        (out_valid && out_ready) |-> (out_flit.hdr.seq_id == rd_ptr))
        else begin
            err_cnt = err_cnt + 1;
            $display("error %0t: sequence id %0d, expected %0d", $time,
                     out_flit.hdr.seq_id, rd_ptr);
        end

    // Stalled output stays put
    assert property (@(negedge clk) disable iff (!rst_n)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_flit)))
        else begin
            err_cnt = err_cnt + 1;
            $display("error %0t: output changed while stalled", $time);
        end

    // Select releases its whole mask with the bypass transfer
    assert property (@(negedge clk) disable iff (!rst_n)
        (out_valid && out_ready && wr_ptr != rd_ptr && exp_mem[rd_ptr].hdr.op == op_select)
            |-> (in_ready == exp_mem[rd_ptr].hdr.exp_mask))
        else begin
            err_cnt = err_cnt + 1;
            $display("error %0t: select readies %b, expected %b", $time, in_ready,
                     exp_mem[rd_ptr].hdr.exp_mask);
        end

    // Readies cover exactly the routes of the item on offer
    assert property (@(negedge clk) disable iff (!rst_n)
        (in_ready != '0) |-> (in_ready == in_valid))
        else begin
            err_cnt = err_cnt + 1;
            $display("error %0t: readies %b, valid routes %b", $time, in_ready, in_valid);
        end

    initial begin
        int      errs;
        red_op_e op;
        logic [15:0] r;
        rst_n    = 1'b0;
        in_valid = '0;
        in_flit  = '0;

        errs = err_cnt;
        repeat (8) @(posedge clk);
        #1;
        rst_n     = 1'b1;
        quiet_chk = 1'b1;
        @(posedge clk);
        #1;
        quiet_chk = 1'b0;
        close_test("reset", errs);

        errs = err_cnt;
        for (int i = 0; i < N_ITEMS; i++) begin
            send_pair(op_add);
        end
        close_test("add", errs);

        errs = err_cnt;
        for (int i = 0; i < N_ITEMS; i++) begin
            send_pair(i[0] ? op_max : op_min);
        end
        close_test("min_max", errs);

        // Select right behind reductions that are still in flight
        errs = err_cnt;
        for (int i = 0; i < N_ITEMS / 3; i++) begin
            pick_op(op);
            send_pair(op);
            pick_op(op);
            send_pair(op);
            send_select();
        end
        close_test("select", errs);

        errs = err_cnt;
        stall_en = 1'b1;
        for (int i = 0; i < N_ITEMS; i++) begin
            rand_bits(2, r);
            if (r[1:0] == 2'd0) begin
                send_select();
            end else begin
                pick_op(op);
                send_pair(op);
            end
        end
        close_test("stall", errs);
        stall_en = 1'b0;

        // Back-to-back pairs fill the pipeline
        errs = err_cnt;
        for (int i = 0; i < N_ITEMS; i++) begin
            pick_op(op);
            send_pair(op);
        end
        close_test("order", errs);

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
                 err_cnt);
        if (tests_failed == 0 && err_cnt == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // Ends the run when a wait loop gives up
    initial begin
        wait (hung);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+rtl
rtl/red_op_pkg.sv
rtl/red_flit_pkg.sv
rtl/red_pair_sched.sv
rtl/red_alu_pipe.sv
rtl/red_hdr_fifo.sv
rtl/red_out_merge.sv
rtl/red_ctrl_top.sv
test/tb_red_ctrl.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_red_ctrl
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard rtl/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -F -q '*** TEST FAILED ***' $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -F -q '*** TEST PASSED ***' $(LOG); then echo "simulation incomplete"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
